// ==== ninjin.f ====
source/ninjin_axi_pkg.sv
source/ninjin_mem_pkg.sv
source/ninjin_burst_decode.sv
source/ninjin_mem_access.sv
source/ninjin_response.sv
source/ninjin_s_axi_renkon.sv
verif/ninjin_s_axi_renkon_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = ninjin_s_axi_renkon_tb
RTL_TOP    = ninjin_s_axi_renkon
FILELIST   = ninjin.f
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/ninjin_s_axi_renkon_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_s_axi_renkon_tb;

  import ninjin_axi_pkg::*;
  import ninjin_mem_pkg::*;

  // total beats of all tests
  localparam int TOTAL_BEATS = 89;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [ID_WIDTH-1:0]   id;
    logic [1:0]            resp;
    logic                  last;
  } r_beat_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } b_beat_t;

  logic                  clk;
  logic                  xrst;
  logic [ID_WIDTH-1:0]   awid, arid, bid, rid;
  logic [ADDR_WIDTH-1:0] awaddr, araddr;
  logic [7:0]            awlen, arlen;
  logic [2:0]            awsize, arsize, awprot, arprot;
  logic [1:0]            awburst, arburst, bresp, rresp;
  logic                  awlock, arlock;
  logic [3:0]            awcache, arcache, awqos, arqos, awregion, arregion;
  logic                  awvalid, awready, arvalid, arready;
  logic [DATA_WIDTH-1:0] wdata, rdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic                  wlast, wvalid, wready;
  logic                  bvalid, bready, rvalid, rready, rlast;

  logic [DATA_WIDTH-1:0] model [MEM_WORDS];
  r_beat_t               exp_r [$];
  b_beat_t               exp_b [$];
  r_beat_t               r_exp;
  b_beat_t               b_exp;
  logic [31:0]           lfsr;
  logic                  gaps;
  int                    errors;
  int                    checks;

  ninjin_s_axi_renkon ninjin_s_axi_renkon_i (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ==============================
  // helpers
  // ==============================

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < width; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // valid or ready level with idle cycles when gaps are on
  function automatic logic handshake_bit();
    if (!gaps)
      return 1'b1;
    return rand_bits(1) == 32'd1;
  endfunction

  // expected word index of beat n
  function automatic logic [MEM_AW-1:0] beat_addr(input logic [ADDR_WIDTH-1:0] start,
                                                  input logic [1:0] burst,
                                                  input logic [7:0] len, input int n);
    addr_u             a;
    logic [MEM_AW-1:0] span;
    a.flat = start;
    // wrap block holds len+1 words
    span = MEM_AW'(len);
    case (burst)
      BURST_FIXED: return a.split.word;
      BURST_WRAP:  return (a.split.word & ~span) | ((a.split.word + MEM_AW'(n)) & span);
      default:     return a.split.word + MEM_AW'(n);
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ==============================
  // master tasks
  // ==============================

  task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [7:0] len, input logic [1:0] burst,
                             input logic rand_strb);
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic [MEM_AW-1:0]     word;
    b_beat_t               b;
    b.id   = id;
    b.resp = (burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
    exp_b.push_back(b);
    @(negedge clk);
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awburst = burst;
    awvalid = 1'b1;
    while (!awready)
      @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    for (int n = 0; n <= len; n++) begin
      data  = rand_bits(DATA_WIDTH);
      strb  = rand_strb ? STRB_WIDTH'(rand_bits(STRB_WIDTH)) : '1;
      wdata = data;
      wstrb = strb;
      wlast = (n == len);
      wvalid = handshake_bit();
      while (!(wvalid && wready)) begin
        @(negedge clk);
        wvalid = handshake_bit();
      end
      @(negedge clk);
      // reserved bursts leave the model untouched
      if (burst != BURST_RSVD) begin
        word = beat_addr(addr, burst, len, n);
        for (int i = 0; i < STRB_WIDTH; i++)
          if (strb[i])
            model[word][8*i +: 8] = data[8*i +: 8];
      end
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    bready = handshake_bit();
    while (!(bvalid && bready)) begin
      @(negedge clk);
      bready = handshake_bit();
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [7:0] len, input logic [1:0] burst);
    r_beat_t b;
    for (int n = 0; n <= len; n++) begin
      b.data = (burst == BURST_RSVD) ? '0 : model[beat_addr(addr, burst, len, n)];
      b.id   = id;
      b.resp = (burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
      b.last = (n == len);
      exp_r.push_back(b);
    end
    @(negedge clk);
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arburst = burst;
    arvalid = 1'b1;
    while (!arready)
      @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    for (int n = 0; n <= len; n++) begin
      rready = handshake_bit();
      while (!(rvalid && rready)) begin
        @(negedge clk);
        rready = handshake_bit();
      end
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  // compare R beats and B responses against the queued expectations
  always @(posedge clk) begin
    if (xrst && rvalid && rready) begin
      if (exp_r.size() == 0) begin
        errors++;
        $display("%0t ns: R beat arrived with no read outstanding", $time);
      end else begin
        r_exp = exp_r.pop_front();
        check("rdata", rdata, r_exp.data);
        check("rid", rid, r_exp.id);
        check("rresp", rresp, r_exp.resp);
        check("rlast", rlast, r_exp.last);
      end
    end
    if (xrst && bvalid && bready) begin
      if (exp_b.size() == 0) begin
        errors++;
        $display("%0t ns: B response arrived with no write outstanding", $time);
      end else begin
        b_exp = exp_b.pop_front();
        check("bid", bid, b_exp.id);
        check("bresp", bresp, b_exp.resp);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, a handshake never completed",
             WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ==============================
  // test sequence
  // ==============================

  initial begin
    lfsr     = 32'h869b;
    gaps     = 1'b0;
    errors   = 0;
    checks   = 0;
    xrst     = 1'b0;
    awid     = '0;
    awaddr   = '0;
    awlen    = '0;
    awsize   = 3'd2;
    awburst  = BURST_INCR;
    awlock   = 1'b0;
    awcache  = '0;
    awprot   = '0;
    awqos    = '0;
    awregion = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wlast    = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    arid     = '0;
    araddr   = '0;
    arlen    = '0;
    arsize   = 3'd2;
    arburst  = BURST_INCR;
    arlock   = 1'b0;
    arcache  = '0;
    arprot   = '0;
    arqos    = '0;
    arregion = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
    check("ready/valid after reset", {awready, arready, wready, bvalid, rvalid}, '0);

    // incr write and read back with rlast on beat 8
    write_burst(12'h101, 12'h040, 8'd7, BURST_INCR, 1'b0);
    read_burst(12'h102, 12'h040, 8'd7, BURST_INCR);

    // wrap of four beats from word 0x82 runs 82 83 80 81
    write_burst(12'h201, 12'h208, 8'd3, BURST_WRAP, 1'b0);
    read_burst(12'h202, 12'h208, 8'd3, BURST_WRAP);
    read_burst(12'h203, 12'h200, 8'd3, BURST_INCR);

    // fixed burst keeps only the last beat
    write_burst(12'h301, 12'h300, 8'd3, BURST_FIXED, 1'b0);
    read_burst(12'h302, 12'h300, 8'd0, BURST_INCR);

    // partial strobes over full words
    write_burst(12'h401, 12'h400, 8'd3, BURST_INCR, 1'b0);
    write_burst(12'h402, 12'h400, 8'd3, BURST_INCR, 1'b1);
    read_burst(12'h403, 12'h400, 8'd3, BURST_INCR);

    // idle cycles on wvalid, bready and rready
    gaps = 1'b1;
    write_burst(12'hA5C, 12'h600, 8'd15, BURST_INCR, 1'b0);
    read_burst(12'h3C1, 12'h600, 8'd15, BURST_INCR);
    gaps = 1'b0;

    // reserved code over the first range followed by a normal read
    write_burst(12'h601, 12'h040, 8'd3, BURST_RSVD, 1'b0);
    read_burst(12'h602, 12'h040, 8'd3, BURST_RSVD);
    read_burst(12'h603, 12'h040, 8'd3, BURST_INCR);

    repeat (4) @(negedge clk);
    if (exp_r.size() != 0 || exp_b.size() != 0) begin
      errors++;
      $display("%0d R beats and %0d B responses never arrived", exp_r.size(), exp_b.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/ninjin_s_axi_renkon.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_s_axi_renkon
  ( input  logic                                  clk
  , input  logic                                  xrst
  , input  logic [ninjin_axi_pkg::ID_WIDTH-1:0]   awid
  , input  logic [ninjin_axi_pkg::ADDR_WIDTH-1:0] awaddr
  , input  logic [7:0]                            awlen
  , input  logic [2:0]                            awsize
  , input  logic [1:0]                            awburst
  , input  logic                                  awlock
  , input  logic [3:0]                            awcache
  , input  logic [2:0]                            awprot
  , input  logic [3:0]                            awqos
  , input  logic [3:0]                            awregion
  , input  logic                                  awvalid
  , input  logic [ninjin_axi_pkg::DATA_WIDTH-1:0] wdata
  , input  logic [ninjin_axi_pkg::STRB_WIDTH-1:0] wstrb
  , input  logic                                  wlast
  , input  logic                                  wvalid
  , input  logic                                  bready
  , input  logic [ninjin_axi_pkg::ID_WIDTH-1:0]   arid
  , input  logic [ninjin_axi_pkg::ADDR_WIDTH-1:0] araddr
  , input  logic [7:0]                            arlen
  , input  logic [2:0]                            arsize
  , input  logic [1:0]                            arburst
  , input  logic                                  arlock
  , input  logic [3:0]                            arcache
  , input  logic [2:0]                            arprot
  , input  logic [3:0]                            arqos
  , input  logic [3:0]                            arregion
  , input  logic                                  arvalid
  , input  logic                                  rready
  , output logic                                  awready
  , output logic                                  wready
  , output logic                                  bvalid
  , output logic [ninjin_axi_pkg::ID_WIDTH-1:0]   bid
  , output logic [1:0]                            bresp
  , output logic                                  arready
  , output logic                                  rvalid
  , output logic [ninjin_axi_pkg::ID_WIDTH-1:0]   rid
  , output logic [ninjin_axi_pkg::DATA_WIDTH-1:0] rdata
  , output logic [1:0]                            rresp
  , output logic                                  rlast
  );

  import ninjin_axi_pkg::*;
  import ninjin_mem_pkg::*;

  axi_req_t              aw_req;
  axi_req_t              ar_req;
  axi_req_t              cur;
  mem_beat_t             beat;
  logic                  beat_en;
  logic                  wr_done;
  logic                  rd_fire;
  logic                  rd_last;
  logic                  b_done;
  logic                  r_taken;
  logic [DATA_WIDTH-1:0] mem_rdata;

  // size, lock, cache, prot, qos and region are not decoded
  assign aw_req = '{id: awid, addr: awaddr, len: awlen, burst: awburst};
  assign ar_req = '{id: arid, addr: araddr, len: arlen, burst: arburst};

  ninjin_burst_decode decode_i
    ( .clk     (clk)
    , .xrst    (xrst)
    , .aw_req  (aw_req)
    , .awvalid (awvalid)
    , .ar_req  (ar_req)
    , .arvalid (arvalid)
    , .wdata   (wdata)
    , .wstrb   (wstrb)
    , .wlast   (wlast)
    , .wvalid  (wvalid)
    , .b_done  (b_done)
    , .r_taken (r_taken)
    , .awready (awready)
    , .arready (arready)
    , .wready  (wready)
    , .beat    (beat)
    , .beat_en (beat_en)
    , .wr_done (wr_done)
    , .rd_fire (rd_fire)
    , .rd_last (rd_last)
    , .cur     (cur)
    );

  ninjin_mem_access mem_i
    ( .clk     (clk)
    , .beat    (beat)
    , .beat_en (beat_en)
    , .rdata   (mem_rdata)
    );

  ninjin_response resp_i
    ( .clk       (clk)
    , .xrst      (xrst)
    , .wr_done   (wr_done)
    , .rd_fire   (rd_fire)
    , .rd_last   (rd_last)
    , .cur       (cur)
    , .rdata     (mem_rdata)
    , .bready    (bready)
    , .rready    (rready)
    , .bvalid    (bvalid)
    , .bid       (bid)
    , .bresp     (bresp)
    , .rvalid    (rvalid)
    , .rid       (rid)
    , .rdata_out (rdata)
    , .rresp     (rresp)
    , .rlast     (rlast)
    , .b_done    (b_done)
    , .r_taken   (r_taken)
    );

endmodule

`default_nettype wire

// ==== source/ninjin_response.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_response
  ( input  logic                                  clk
  , input  logic                                  xrst
  , input  logic                                  wr_done
  , input  logic                                  rd_fire
  , input  logic                                  rd_last
  , input  ninjin_axi_pkg::axi_req_t              cur
  , input  logic [ninjin_axi_pkg::DATA_WIDTH-1:0] rdata
  , input  logic                                  bready
  , input  logic                                  rready
  , output logic                                  bvalid
  , output logic [ninjin_axi_pkg::ID_WIDTH-1:0]   bid
  , output logic [1:0]                            bresp
  , output logic                                  rvalid
  , output logic [ninjin_axi_pkg::ID_WIDTH-1:0]   rid
  , output logic [ninjin_axi_pkg::DATA_WIDTH-1:0] rdata_out
  , output logic [1:0]                            rresp
  , output logic                                  rlast
  , output logic                                  b_done
  , output logic                                  r_taken
  );

  import ninjin_axi_pkg::*;

  logic [1:0] cur_resp;

  // only the reserved burst code is an error
  assign cur_resp = (cur.burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;

  assign b_done  = bvalid && bready;
  assign r_taken = rvalid && rready;

  // ==============================
  // write response
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst)
      bvalid <= 1'b0;
    else if (wr_done)
      bvalid <= 1'b1;
    else if (bready)
      bvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (wr_done) begin
      bid   <= cur.id;
      bresp <= cur_resp;
    end
  end

  // ==============================
  // read data
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst)
      rvalid <= 1'b0;
    else if (rd_fire)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  // beat attributes travel alongside the memory read
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rid   <= cur.id;
      rresp <= cur_resp;
      rlast <= rd_last;
    end
  end

  // error beats carry zero data
  assign rdata_out = (rresp == RESP_SLVERR) ? '0 : rdata;

endmodule

`default_nettype wire

// ==== source/ninjin_mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_mem_access
  ( input  logic                                  clk
  , input  ninjin_mem_pkg::mem_beat_t             beat
  , input  logic                                  beat_en
  , output logic [ninjin_axi_pkg::DATA_WIDTH-1:0] rdata
  );

  import ninjin_axi_pkg::*;
  import ninjin_mem_pkg::*;

  // ==============================
  // word array
  // ==============================

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (beat_en) begin
      if (beat.we) begin
        // byte lanes gated by strobe
        for (int i = 0; i < STRB_WIDTH; i++) begin
          if (beat.strb[i])
            mem[beat.word][8*i +: 8] <= beat.wdata[8*i +: 8];
        end
      end else begin
        // read data appears the next cycle
        rdata <= mem[beat.word];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ninjin_burst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ninjin_burst_decode
  ( input  logic                                  clk
  , input  logic                                  xrst
  , input  ninjin_axi_pkg::axi_req_t              aw_req
  , input  logic                                  awvalid
  , input  ninjin_axi_pkg::axi_req_t              ar_req
  , input  logic                                  arvalid
  , input  logic [ninjin_axi_pkg::DATA_WIDTH-1:0] wdata
  , input  logic [ninjin_axi_pkg::STRB_WIDTH-1:0] wstrb
  , input  logic                                  wlast
  , input  logic                                  wvalid
  , input  logic                                  b_done
  , input  logic                                  r_taken
  , output logic                                  awready
  , output logic                                  arready
  , output logic                                  wready
  , output ninjin_mem_pkg::mem_beat_t             beat
  , output logic                                  beat_en
  , output logic                                  wr_done
  , output logic                                  rd_fire
  , output logic                                  rd_last
  , output ninjin_axi_pkg::axi_req_t              cur
  );

  import ninjin_axi_pkg::*;
  import ninjin_mem_pkg::*;

  typedef enum logic [2:0] {IDLE, WRITE, WRESP, RISSUE, RWAIT} state_t;

  state_t               state;
  addr_u                addr;
  logic [CNT_WIDTH-1:0] cnt;
  logic                 w_fire;
  logic                 rsvd;

  // address of the following beat
  function automatic addr_u next_addr(input addr_u a, input axi_req_t r);
    addr_u                 n;
    logic [ADDR_WIDTH-1:0] mask;
    n.split.word   = a.split.word + 1'b1;
    n.split.offset = '0;
    // wrap block is (len+1) words
    mask = {({2'b00, r.len} + 10'd1), 2'b00} - 1'b1;
    case (r.burst)
      BURST_FIXED: n = a;
      BURST_WRAP:  n.flat = (a.flat & ~mask) | (n.flat & mask);
      default:     ;
    endcase
    return n;
  endfunction

  assign w_fire  = wready && wvalid;
  assign rsvd    = (cur.burst == BURST_RSVD);
  assign wready  = (state == WRITE);
  assign rd_fire = (state == RISSUE);
  assign rd_last = (cnt == cur.len);
  assign wr_done = w_fire && wlast;

  // reserved bursts never touch the array on writes
  assign beat_en = (w_fire && !rsvd) || rd_fire;

  always_comb begin
    beat.we    = (state == WRITE);
    beat.word  = addr.split.word;
    beat.wdata = wdata;
    beat.strb  = wstrb;
  end

  // ==============================
  // transaction FSM
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= IDLE;
      awready <= 1'b0;
      arready <= 1'b0;
      cnt     <= '0;
    end else begin
      case (state)
        IDLE:
          if (awready) begin
            awready <= 1'b0;
            state   <= WRITE;
          end else if (arready) begin
            arready <= 1'b0;
            cnt     <= '0;
            state   <= RISSUE;
          end else if (awvalid) begin
            // write wins a tie
            awready <= 1'b1;
          end else if (arvalid) begin
            arready <= 1'b1;
          end
        WRITE:
          if (wr_done)
            state <= WRESP;
        WRESP:
          if (b_done)
            state <= IDLE;
        RISSUE:
          state <= RWAIT;
        RWAIT:
          if (r_taken) begin
            if (rd_last) begin
              state <= IDLE;
            end else begin
              cnt   <= cnt + 1'b1;
              state <= RISSUE;
            end
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // request capture and address stepping
  always_ff @(posedge clk) begin
    if (awready) begin
      cur       <= aw_req;
      addr.flat <= aw_req.addr;
    end else if (arready) begin
      cur       <= ar_req;
      addr.flat <= ar_req.addr;
    end else if (w_fire || (state == RWAIT && r_taken)) begin
      addr <= next_addr(addr, cur);
    end
  end

endmodule

`default_nettype wire

// ==== source/ninjin_mem_pkg.sv ====
`default_nettype none

package ninjin_mem_pkg;

  // ==============================
  // memory geometry
  // ==============================

  localparam int LSB       = 2;
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  typedef struct packed {
    logic [MEM_AW-1:0] word;
    logic [LSB-1:0]    offset;
  } addr_split_t;

  // byte address, seen whole or as word index plus byte offset
  typedef union packed {
    logic [MEM_AW+LSB-1:0] flat;
    addr_split_t           split;
  } addr_u;

  // one memory operation
  typedef struct packed {
    logic                                  we;
    logic [MEM_AW-1:0]                     word;
    logic [ninjin_axi_pkg::DATA_WIDTH-1:0] wdata;
    logic [ninjin_axi_pkg::STRB_WIDTH-1:0] strb;
  } mem_beat_t;

endpackage

`default_nettype wire

// ==== source/ninjin_axi_pkg.sv ====
`default_nettype none

package ninjin_axi_pkg;

  // ==============================
  // bus geometry
  // ==============================

  localparam int ID_WIDTH   = 12;
  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // beat counter spans the whole len field
  localparam int CNT_WIDTH  = 8;

  // ==============================
  // burst and response codes
  // ==============================

  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;
  localparam logic [1:0] BURST_RSVD  = 2'b11;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // captured address request, same shape for AW and AR
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [CNT_WIDTH-1:0]  len;
    logic [1:0]            burst;
  } axi_req_t;

endpackage

`default_nettype wire
